/* sim.f */
hdl/cpu85_pkg.sv
hdl/alu85.sv
hdl/bus_timing.sv
hdl/instr_decode.sv
hdl/reg_file.sv
hdl/cpu85_top.sv
verif/tb_mem_model.sv
verif/tb_cpu85.sv

/* Bender.yml */
package:
  name: cpu85

sources:
  - files:
      - hdl/cpu85_pkg.sv
      - hdl/alu85.sv
      - hdl/bus_timing.sv
      - hdl/instr_decode.sv
      - hdl/reg_file.sv
      - hdl/cpu85_top.sv
  - target: simulation
    files:
      - verif/tb_mem_model.sv
      - verif/tb_cpu85.sv

/* verif/tb_cpu85.sv */
`timescale 1ns/1ps

module tb_cpu85;

	localparam int ADDR_W = 16;
	localparam int ROWS = 16;
	localparam int HALT_LIMIT = 2000; // cycles
	localparam int QUIET_CYCLES = 50;

	logic clk, rst, wait_en, ready;
	logic [7:0] rd_data, ad, addr_hi;
	logic ad_oe, ale, rd_n, wr_n, iom_n, s1, s0;

	logic [95:0] prog [ROWS]; // byte 0 in the top bits
	logic waits [ROWS];
	int n_wr [ROWS];
	logic [63:0] wr_addr_exp [ROWS]; // first write in the top bits
	logic [31:0] wr_data_exp [ROWS];
	int ale_exp [ROWS];
	int rows, errors, test_err, passed;

	cpu85_top #(.ADDR_W(ADDR_W)) u_dut (
		.clk(clk), .rst(rst), .i_ready(ready), .i_ad(rd_data),
		.o_ad(ad), .o_ad_oe(ad_oe), .o_addr_hi(addr_hi), .o_ale(ale),
		.o_rd_n(rd_n), .o_wr_n(wr_n), .o_iom_n(iom_n), .o_s1(s1), .o_s0(s0)
	);

	tb_mem_model #(.ADDR_W(ADDR_W)) u_mem (
		.clk(clk), .rst(rst), .i_wait_en(wait_en), .i_ad(ad), .i_ad_oe(ad_oe),
		.i_addr_hi(addr_hi), .i_ale(ale), .i_rd_n(rd_n), .i_wr_n(wr_n),
		.i_iom_n(iom_n), .o_rd_data(rd_data), .o_ready(ready)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic add_row(input logic [95:0] p, input logic w, input int n,
			input logic [63:0] a, input logic [31:0] d, input int ale_n);
		prog[rows] = p;
		waits[rows] = w;
		n_wr[rows] = n;
		wr_addr_exp[rows] = a;
		wr_data_exp[rows] = d;
		ale_exp[rows] = ale_n;
		rows++;
	endtask

	task automatic build_table();
		// mem[a] = a ^ a5 outside the program, so mem[80] = 25
		add_row(96'h26002E40065A707600000000, 1'b0, 1, 64'h0040000000000000, 32'h5A000000, 9);
		add_row(96'h26002E4106C348515A7B7776, 1'b0, 1, 64'h0041000000000000, 32'hC3000000, 13);
		add_row(96'h3EF00620808826002E507776, 1'b0, 1, 64'h0050000000000000, 32'h31000000, 13);
		add_row(96'h26002E603E30959D77760000, 1'b0, 1, 64'h0060000000000000, 32'h6F000000, 11);
		add_row(96'h26002E3C3EF087A58D777600, 1'b0, 1, 64'h003C000000000000, 32'h5C000000, 12);
		add_row(96'h26002E5A3E0FBDB5AD8D7776, 1'b0, 1, 64'h005A000000000000, 32'h5F000000, 13);
		add_row(96'h26002E703E20BD8D77760000, 1'b0, 1, 64'h0070000000000000, 32'h91000000, 11);
		add_row(96'h26002E80463E118677687076, 1'b0, 2, 64'h0080002500000000, 32'h36250000, 16);
		// same programs again with random READY
		for (int i = 0; i < 8; i++) begin
			add_row(prog[i], 1'b1, n_wr[i], wr_addr_exp[i], wr_data_exp[i], ale_exp[i]);
		end
	endtask

	task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp) begin
			$display("FAILED %s: got %h, expected %h", name, got, exp);
			test_err++;
		end
	endtask

	task automatic check_addr(input string name, input logic [ADDR_W-1:0] got,
			input logic [ADDR_W-1:0] exp);
		if (got !== exp) begin
			$display("FAILED %s: got %h, expected %h", name, got, exp);
			test_err++;
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		if (got != exp) begin
			$display("FAILED %s: got %h, expected %h", name, got, exp);
			test_err++;
		end
	endtask

	task automatic run_row(input int r);
		int cycles;
		int ale_at_halt;
		logic halted;
		test_err = 0;
		@(posedge clk);
		rst <= 1'b1;
		wait_en <= waits[r];
		for (int a = 0; a < 256; a++) begin
			u_mem.mem[a] = a[7:0] ^ 8'ha5;
		end
		for (int i = 0; i < 12; i++) begin
			u_mem.mem[i] = prog[r][95-8*i -: 8];
		end
		repeat (5) @(posedge clk);
		rst <= 1'b0;
		cycles = 0;
		halted = 1'b0;
		while (!halted && cycles < HALT_LIMIT) begin
			@(posedge clk);
			cycles++;
			halted = !s1 && !s0 && rd_n && wr_n; // TT status
		end
		if (!halted) begin
			$display("test %0d: no halt status within %0d cycles", r, HALT_LIMIT);
			test_err++;
		end else begin
			ale_at_halt = u_mem.ale_cnt;
			check_count("ale_count", ale_at_halt, ale_exp[r]);
			check_count("iom_n_high_at_ale", u_mem.io_cnt, 0);
			check_count("write_count", u_mem.wr_cnt, n_wr[r]);
			for (int i = 0; i < n_wr[r] && i < u_mem.wr_cnt; i++) begin
				check_addr("write_addr", u_mem.wr_addr_log[i], wr_addr_exp[r][63-16*i -: 16]);
				check_byte("write_data", u_mem.wr_data_log[i], wr_data_exp[r][31-8*i -: 8]);
			end
			check_count("write_strobe_errors", u_mem.wr_bad, 0);
			repeat (QUIET_CYCLES) @(posedge clk);
			check_count("ale_after_halt", u_mem.ale_cnt, ale_at_halt);
		end
		if (test_err == 0) begin
			passed++;
			$display("test %0d (waits %0d): ok", r, waits[r]);
		end else begin
			$display("test %0d (waits %0d): %0d errors", r, waits[r], test_err);
		end
		errors += test_err;
	endtask

	initial begin
		rst = 1'b1;
		wait_en = 1'b0;
		rows = 0;
		errors = 0;
		passed = 0;
		build_table();
		for (int r = 0; r < rows; r++) begin
			run_row(r);
		end
		$display("%0d of %0d tests passed, %0d errors", passed, rows, errors);
		if (errors == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

/* verif/tb_mem_model.sv */
`timescale 1ns/1ps

module tb_mem_model #(
	parameter int ADDR_W = 16
) (
	input  logic       clk,
	input  logic       rst,
	input  logic       i_wait_en,
	input  logic [7:0] i_ad,
	input  logic       i_ad_oe,
	input  logic [7:0] i_addr_hi,
	input  logic       i_ale,
	input  logic       i_rd_n,
	input  logic       i_wr_n,
	input  logic       i_iom_n,
	output logic [7:0] o_rd_data,
	output logic       o_ready
);

	logic [7:0] mem [256];
	logic [ADDR_W-1:0] lat_addr;
	logic [7:0] wr_byte;
	logic [ADDR_W-1:0] wr_addr_log [16];
	logic [7:0] wr_data_log [16];
	int ale_cnt, wr_cnt, wr_bad, low_cnt, io_cnt;
	integer seed;

	initial begin
		seed = 32'hbd75fa45;
		o_ready = 1'b1;
		o_rd_data = 8'h00;
	end

	always @(posedge clk) begin
		if (rst) begin
			ale_cnt <= 0;
			wr_cnt <= 0;
			wr_bad <= 0;
			low_cnt <= 0;
			io_cnt <= 0;
			o_ready <= 1'b1;
		end else begin
			o_ready <= i_wait_en ? (($random(seed) & 3) != 0) : 1'b1; // low about one in four
			if (i_ale) begin
				lat_addr <= {i_addr_hi, i_ad};
				ale_cnt <= ale_cnt + 1;
				if (i_iom_n) io_cnt <= io_cnt + 1; // cycle marked as I/O
			end
			if (!i_rd_n) o_rd_data <= mem[lat_addr[7:0]];
			if (!i_wr_n) begin
				low_cnt <= low_cnt + 1;
				wr_byte <= i_ad;
				if (!i_ad_oe) wr_bad <= wr_bad + 1; // bus not driven during write
			end else if (low_cnt != 0) begin
				// strobe released, cycle is complete
				if (wr_cnt < 16) begin
					wr_addr_log[wr_cnt] <= lat_addr;
					wr_data_log[wr_cnt] <= wr_byte;
				end
				mem[lat_addr[7:0]] <= wr_byte;
				if (low_cnt < 2) wr_bad <= wr_bad + 1; // T2 and T3 at least
				wr_cnt <= wr_cnt + 1;
				low_cnt <= 0;
			end
		end
	end

endmodule

/* hdl/cpu85_top.sv */
`timescale 1ns/1ps

module cpu85_top import cpu85_pkg::*; #(
	parameter int ADDR_W = 16
) (
	input  logic       clk,
	input  logic       rst,
	input  logic       i_ready,
	input  logic [7:0] i_ad,
	output logic [7:0] o_ad,
	output logic       o_ad_oe,
	output logic [7:0] o_addr_hi,
	output logic       o_ale,
	output logic       o_rd_n,
	output logic       o_wr_n,
	output logic       o_iom_n,
	output logic       o_s1,
	output logic       o_s0
);

	opcode_u ir;
	alu_op_e alu_op;
	logic [ADDR_W-1:0] addr;
	logic [7:0] acc, src_data, alu_res;
	logic [2:0] dst, src;
	logic alu_carry, carry;
	logic mem_cycle, mem_write, dec_use_hl, halt;
	logic is_alu, is_mvi, reg_write;
	logic data_phase, ir_load, rd_load, exec, pc_inc, bus_use_hl;

	// low byte carries address in T1, write data after
	assign o_ad = data_phase ? src_data : addr[7:0];
	assign o_addr_hi = addr[ADDR_W-1 -: 8];

	bus_timing u_bus (
		.clk(clk), .rst(rst), .i_ready(i_ready),
		.i_mem_cycle(mem_cycle), .i_mem_write(mem_write),
		.i_use_hl(dec_use_hl), .i_halt(halt),
		.o_ale(o_ale), .o_rd_n(o_rd_n), .o_wr_n(o_wr_n), .o_iom_n(o_iom_n),
		.o_s1(o_s1), .o_s0(o_s0), .o_ad_oe(o_ad_oe), .o_data_phase(data_phase),
		.o_ir_load(ir_load), .o_rd_load(rd_load), .o_exec(exec),
		.o_pc_inc(pc_inc), .o_use_hl(bus_use_hl)
	);

	instr_decode u_dec (
		.i_ir(ir),
		.o_mem_cycle(mem_cycle), .o_mem_write(mem_write), .o_use_hl(dec_use_hl),
		.o_halt(halt), .o_dst(dst), .o_src(src), .o_alu_op(alu_op),
		.o_is_alu(is_alu), .o_is_mvi(is_mvi), .o_reg_write(reg_write)
	);

	reg_file #(.ADDR_W(ADDR_W)) u_regs (
		.clk(clk), .rst(rst),
		.i_ir_load(ir_load), .i_rd_load(rd_load), .i_exec(exec),
		.i_pc_inc(pc_inc), .i_use_hl(bus_use_hl), .i_bus_data(i_ad),
		.i_dst(dst), .i_src(src), .i_is_alu(is_alu), .i_is_mvi(is_mvi),
		.i_reg_write(reg_write), .i_alu_res(alu_res), .i_alu_carry(alu_carry),
		.o_ir(ir), .o_addr(addr), .o_acc(acc), .o_src_data(src_data),
		.o_carry(carry)
	);

	alu85 u_alu (
		.i_op(alu_op), .i_a(acc), .i_b(src_data), .i_carry(carry),
		.o_res(alu_res), .o_carry(alu_carry)
	);

endmodule

/* hdl/reg_file.sv */
`timescale 1ns/1ps

module reg_file import cpu85_pkg::*; #(
	parameter int ADDR_W = 16
) (
	input  logic              clk,
	input  logic              rst,
	input  logic              i_ir_load,
	input  logic              i_rd_load,
	input  logic              i_exec,
	input  logic              i_pc_inc,
	input  logic              i_use_hl,
	input  logic [7:0]        i_bus_data,
	input  logic [2:0]        i_dst,
	input  logic [2:0]        i_src,
	input  logic              i_is_alu,
	input  logic              i_is_mvi,
	input  logic              i_reg_write,
	input  logic [7:0]        i_alu_res,
	input  logic              i_alu_carry,
	output opcode_u           o_ir,
	output logic [ADDR_W-1:0] o_addr,
	output logic [7:0]        o_acc,
	output logic [7:0]        o_src_data,
	output logic              o_carry
);

	logic [7:0] r_b, r_c, r_d, r_e, r_h, r_l, r_a;
	logic [FLAG_C:0] psw; // flag bits, carry only
	logic [ADDR_W-1:0] pc;
	logic [7:0] src_reg, wr_data;
	logic wr_strobe, from_bus;

	assign wr_strobe = i_exec | i_rd_load;
	assign from_bus = i_is_mvi | (i_src == REG_M); // operand arrives on the bus

	always_comb begin
		case (i_src)
			REG_B: src_reg = r_b;
			REG_C: src_reg = r_c;
			REG_D: src_reg = r_d;
			REG_E: src_reg = r_e;
			REG_H: src_reg = r_h;
			REG_L: src_reg = r_l;
			REG_A: src_reg = r_a;
			default: src_reg = 8'h00;
		endcase
	end

	assign o_src_data = from_bus ? i_bus_data : src_reg;
	assign wr_data = i_is_alu ? i_alu_res : o_src_data;

	always_ff @(posedge clk) begin
		if (i_reg_write && wr_strobe) begin
			case (i_dst)
				REG_B: r_b <= wr_data;
				REG_C: r_c <= wr_data;
				REG_D: r_d <= wr_data;
				REG_E: r_e <= wr_data;
				REG_H: r_h <= wr_data;
				REG_L: r_l <= wr_data;
				REG_A: r_a <= wr_data;
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			pc <= '0;
			o_ir <= '0;
			psw <= '0;
		end else begin
			if (i_pc_inc) pc <= pc + 1'b1;
			if (i_ir_load) o_ir <= i_bus_data;
			if (i_is_alu && wr_strobe) psw[FLAG_C] <= i_alu_carry;
		end
	end

	assign o_addr = i_use_hl ? ADDR_W'({r_h, r_l}) : pc;
	assign o_acc = r_a;
	assign o_carry = psw[FLAG_C];

endmodule

/* hdl/instr_decode.sv */
`timescale 1ns/1ps

module instr_decode import cpu85_pkg::*; (
	input  opcode_u    i_ir,
	output logic       o_mem_cycle,
	output logic       o_mem_write,
	output logic       o_use_hl,
	output logic       o_halt,
	output logic [2:0] o_dst,
	output logic [2:0] o_src,
	output alu_op_e    o_alu_op,
	output logic       o_is_alu,
	output logic       o_is_mvi,
	output logic       o_reg_write
);

	logic [1:0] grp;
	logic is_hlt, is_mov, is_alu, is_mvi;
	logic dst_m, src_m;

	assign grp = i_ir.mov.grp;

	assign is_hlt = (i_ir == OPC_HLT); // not MOV M,M
	assign is_mov = (grp == GRP_MOV) & ~is_hlt;
	assign is_alu = (grp == GRP_ALU);

	// MVI r; MVI M is not supported
	assign is_mvi = (grp == GRP_TXA) & (i_ir.mov.src == OPC_MVI_LOW)
		& (i_ir.mov.dst != REG_M);

	// move view vs ALU view of the same byte
	assign dst_m = is_mov & (i_ir.mov.dst == REG_M);
	assign src_m = is_alu ? (i_ir.alu.src == REG_M) : (is_mov & (i_ir.mov.src == REG_M));

	assign o_src = i_ir.mov.src; // same bits in both views
	assign o_dst = is_alu ? REG_A : i_ir.mov.dst;
	assign o_alu_op = i_ir.alu.op;

	assign o_mem_cycle = is_mvi | dst_m | src_m;
	assign o_mem_write = dst_m;
	assign o_use_hl = dst_m | src_m; // MVI operand comes from PC
	assign o_halt = is_hlt;

	assign o_is_alu = is_alu;
	assign o_is_mvi = is_mvi;

	// CMP only touches carry
	assign o_reg_write = (is_mov & ~dst_m) | is_mvi | (is_alu & (i_ir.alu.op != ALU_CMP));

endmodule

/* hdl/bus_timing.sv */
`timescale 1ns/1ps

module bus_timing import cpu85_pkg::*; (
	input  logic clk,
	input  logic rst,
	input  logic i_ready,
	input  logic i_mem_cycle,
	input  logic i_mem_write,
	input  logic i_use_hl,
	input  logic i_halt,
	output logic o_ale,
	output logic o_rd_n,
	output logic o_wr_n,
	output logic o_iom_n,
	output logic o_s1,
	output logic o_s0,
	output logic o_ad_oe,
	output logic o_data_phase,
	output logic o_ir_load,
	output logic o_rd_load,
	output logic o_exec,
	output logic o_pc_inc,
	output logic o_use_hl
);

	mstate_e state, state_nx;
	logic [CYC_W-1:0] code; // status and strobes of current cycle
	logic fetch;
	logic strobe_phase;

	// only opcode fetch shows s1s0 = 11
	assign fetch = code[STAT_S1] & code[STAT_S0];
	assign strobe_phase = (state == ST_T2) | (state == ST_TW) | (state == ST_T3);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= ST_TR;
			code <= CYC_OF;
		end else begin
			state <= state_nx;
			if (state_nx == ST_T1) begin
				// at most one memory cycle follows the fetch
				if (state == ST_T4 && i_mem_cycle) begin
					code <= i_mem_write ? CYC_MW : CYC_MR;
				end else begin
					code <= CYC_OF;
				end
			end
		end
	end

	always_comb begin
		state_nx = state;
		case (state)
			ST_TR: state_nx = ST_T1;
			ST_T1: state_nx = ST_T2;
			ST_T2: state_nx = i_ready ? ST_T3 : ST_TW;
			ST_TW: state_nx = i_ready ? ST_T3 : ST_TW;
			ST_T3: state_nx = fetch ? ST_T4 : ST_T1;
			ST_T4: state_nx = i_halt ? ST_TT : ST_T1;
			ST_TT: state_nx = ST_TT; // only reset leaves
			default: state_nx = ST_TR;
		endcase
	end

	// pin levels per machine state
	always_comb begin
		o_ale = 1'b0;
		o_rd_n = 1'b1;
		o_wr_n = 1'b1;
		o_iom_n = code[STAT_IOM_N];
		o_s1 = code[STAT_S1];
		o_s0 = code[STAT_S0];
		o_ad_oe = 1'b0;
		o_data_phase = 1'b0;
		case (state)
			ST_T1: begin
				o_ale = 1'b1;
				o_ad_oe = 1'b1; // low address byte
			end
			ST_T2, ST_TW, ST_T3: begin
				o_rd_n = code[CTRL_RD_N];
				o_wr_n = code[CTRL_WR_N];
				o_data_phase = ~code[CTRL_WR_N]; // drive write data
				o_ad_oe = ~code[CTRL_WR_N];
			end
			ST_T4: begin
				o_s1 = 1'b1;
				o_s0 = 1'b1;
			end
			ST_TT: begin
				o_iom_n = CYC_HLT[STAT_IOM_N];
				o_s1 = CYC_HLT[STAT_S1];
				o_s0 = CYC_HLT[STAT_S0];
			end
			default: ;
		endcase
	end

	// opcode lands in IR at the end of T3
	assign o_ir_load = (state == ST_T3) & fetch;
	assign o_rd_load = (state == ST_T3) & ~fetch & ~code[CTRL_RD_N];
	assign o_exec = (state == ST_T4) & ~i_mem_cycle;

	// PC steps once READY is seen, so the high byte holds through waits
	assign o_pc_inc = strobe_phase & (state != ST_T3) & i_ready & (fetch | ~i_use_hl);
	assign o_use_hl = ~fetch & i_use_hl;

endmodule

/* hdl/alu85.sv */
`timescale 1ns/1ps

module alu85 import cpu85_pkg::*; (
	input  alu_op_e    i_op,
	input  logic [7:0] i_a,
	input  logic [7:0] i_b,
	input  logic       i_carry,
	output logic [7:0] o_res,
	output logic       o_carry
);

	logic [8:0] a_ext, b_ext;
	logic [8:0] sum; // bit 8 is carry or borrow

	assign a_ext = {1'b0, i_a};
	assign b_ext = {1'b0, i_b};

	always_comb begin
		case (i_op)
			ALU_ADD: begin
				sum = a_ext + b_ext;
			end
			ALU_ADC: begin
				sum = a_ext + b_ext + {8'd0, i_carry};
			end
			ALU_SUB, ALU_CMP: begin
				// wraps below zero, bit 8 set on borrow
				sum = a_ext - b_ext;
			end
			ALU_SBB: begin
				sum = a_ext - b_ext - {8'd0, i_carry};
			end
			ALU_ANA: begin
				sum = {1'b0, i_a & i_b}; // carry cleared
			end
			ALU_XRA: begin
				sum = {1'b0, i_a ^ i_b};
			end
			ALU_ORA: begin
				sum = {1'b0, i_a | i_b};
			end
			default: begin
				sum = 9'd0;
			end
		endcase
	end

	// result modulo 256
	assign o_res = sum[7:0];
	assign o_carry = sum[8];

endmodule

/* hdl/cpu85_pkg.sv */
package cpu85_pkg;

	// instruction groups, top two opcode bits
	localparam logic [1:0] GRP_TXA = 2'b00; // only MVI kept here
	localparam logic [1:0] GRP_MOV = 2'b01;
	localparam logic [1:0] GRP_ALU = 2'b10;

	// register field codes
	localparam logic [2:0] REG_B = 3'd0;
	localparam logic [2:0] REG_C = 3'd1;
	localparam logic [2:0] REG_D = 3'd2;
	localparam logic [2:0] REG_E = 3'd3;
	localparam logic [2:0] REG_H = 3'd4;
	localparam logic [2:0] REG_L = 3'd5;
	localparam logic [2:0] REG_M = 3'd6; // memory at H:L
	localparam logic [2:0] REG_A = 3'd7;

	localparam logic [7:0] OPC_HLT = 8'h76; // would be MOV M,M
	localparam logic [2:0] OPC_MVI_LOW = 3'b110;

	// carry position in the flag byte
	localparam int FLAG_C = 0;

	typedef enum logic [2:0] {
		ALU_ADD, ALU_ADC, ALU_SUB, ALU_SBB,
		ALU_ANA, ALU_XRA, ALU_ORA, ALU_CMP
	} alu_op_e;

	// one-hot machine states
	typedef enum logic [6:0] {
		ST_TR = 7'b000_0001, // reset
		ST_T1 = 7'b000_0010,
		ST_T2 = 7'b000_0100,
		ST_T3 = 7'b000_1000,
		ST_T4 = 7'b001_0000,
		ST_TW = 7'b010_0000, // wait
		ST_TT = 7'b100_0000 // halted
	} mstate_e;

	// cycle code {inta_n, wr_n, rd_n, iom_n, s1, s0}
	localparam int CYC_W = 6;
	localparam logic [CYC_W-1:0] CYC_OF = 6'b110011; // opcode fetch
	localparam logic [CYC_W-1:0] CYC_MR = 6'b110010; // memory read
	localparam logic [CYC_W-1:0] CYC_MW = 6'b101001; // memory write
	localparam logic [CYC_W-1:0] CYC_HLT = 6'b111100;

	localparam int STAT_S0 = 0;
	localparam int STAT_S1 = 1;
	localparam int STAT_IOM_N = 2;
	localparam int CTRL_RD_N = 3;
	localparam int CTRL_WR_N = 4;

	typedef struct packed {
		logic [1:0] grp;
		logic [2:0] dst;
		logic [2:0] src;
	} mov_view_t;

	typedef struct packed {
		logic [1:0] grp;
		alu_op_e op;
		logic [2:0] src;
	} alu_view_t;

	typedef union packed {
		mov_view_t mov;
		alu_view_t alu;
	} opcode_u;

endpackage
